// ==== fetch_pkg.sv ====
package fetch_pkg;

  // Address and instruction word
  typedef logic [31:0] word_t;

  // First fetch address out of reset
  localparam word_t RESET_PC = 32'h200;

  // BTB geometry
  // Index from PC bits 5:2, tag from bits 31:6
  localparam int BTB_ENTRIES = 16;
  localparam int BTB_IDX_W = 4;
  localparam int BTB_TAG_W = 26;

  // Output packet FIFO
  localparam int QUEUE_DEPTH = 4;
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

  // Credits granted by the execute stage
  localparam int EXEC_CREDITS = 4;
  // Wide enough to hold the full grant
  localparam int CREDIT_W = $clog2(EXEC_CREDITS + 1);

  // Set when the bus delivers little-endian words
  localparam logic BUS_LITTLE_ENDIAN = 1'b1;

  // Fetch FSM
  // HALT only after a misaligned PC, left by redirect
  typedef enum logic {
    FETCH_RUN,
    FETCH_HALT
  } fetch_state_e;

  // 2-bit saturating counter
  // Upper bit set means predict taken
  typedef enum logic [1:0] {
    STRONG_NT,
    WEAK_NT,
    WEAK_T,
    STRONG_T
  } ctr_e;

endpackage

// ==== fetch_bus_port.sv ====
module fetch_bus_port (
  input  logic              CLK,
  input  logic              nRST,
  input  fetch_pkg::word_t  req_addr,
  input  logic              req_en,
  input  logic              flush,
  output fetch_pkg::word_t  imem_addr,
  output logic              imem_ren,
  input  logic              imem_busy,
  input  fetch_pkg::word_t  imem_rdata,
  output logic              req_done,
  output logic              resp_valid,
  output fetch_pkg::word_t  resp_instr
);

  // Goes high one cycle after reset release
  logic bus_armed;
  // Returned word in core byte order
  fetch_pkg::word_t rdata_fixed;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      bus_armed <= 1'b0;
    end else begin
      bus_armed <= 1'b1;
    end
  end

  // Address follows the PC, may move while busy
  assign imem_addr = req_addr;
  assign imem_ren  = req_en & bus_armed;

  // Access completes when not busy
  assign req_done = imem_ren & ~imem_busy;

  // Endianness correction
  generate
    if (fetch_pkg::BUS_LITTLE_ENDIAN) begin : g_swap
      assign rdata_fixed = {imem_rdata[7:0], imem_rdata[15:8],
                            imem_rdata[23:16], imem_rdata[31:24]};
    end else begin : g_noswap
      assign rdata_fixed = imem_rdata;
    end
  endgenerate

  // One-cycle response pulse
  // Flush in the completing cycle drops it here
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= req_done & ~flush;
    end
  end

  // Payload register
  always_ff @(posedge CLK) begin
    if (req_done) begin
      resp_instr <= rdata_fixed;
    end
  end

  // Only word-aligned reads ever reach the bus
  assert property (@(posedge CLK) disable iff (!nRST)
    imem_ren |-> (imem_addr[1:0] == 2'b00));

endmodule

// ==== branch_predictor.sv ====
module branch_predictor (
  input  logic              CLK,
  input  logic              nRST,
  input  fetch_pkg::word_t  lookup_pc,
  output logic              predict_taken,
  output fetch_pkg::word_t  target_addr,
  input  logic              update_en,
  input  fetch_pkg::word_t  resolve_pc,
  input  fetch_pkg::word_t  resolve_target,
  input  logic              resolve_taken
);

  // Per-entry state
  logic [fetch_pkg::BTB_ENTRIES-1:0] valid;
  logic [fetch_pkg::BTB_TAG_W-1:0]   tag_mem [fetch_pkg::BTB_ENTRIES];
  fetch_pkg::word_t                  tgt_mem [fetch_pkg::BTB_ENTRIES];
  fetch_pkg::ctr_e                   ctr_mem [fetch_pkg::BTB_ENTRIES];

  logic [fetch_pkg::BTB_IDX_W-1:0] lk_idx;
  logic [fetch_pkg::BTB_TAG_W-1:0] lk_tag;
  logic                            lk_hit;
  logic [fetch_pkg::BTB_IDX_W-1:0] up_idx;
  logic [fetch_pkg::BTB_TAG_W-1:0] up_tag;
  logic                            up_hit;

  // Lookup side, word index above the two low bits
  assign lk_idx = lookup_pc[fetch_pkg::BTB_IDX_W+1:2];
  assign lk_tag = lookup_pc[31:fetch_pkg::BTB_IDX_W+2];
  assign lk_hit = valid[lk_idx] && (tag_mem[lk_idx] == lk_tag);

  // Taken for WEAK_T and STRONG_T
  assign predict_taken = lk_hit && ctr_mem[lk_idx][1];
  assign target_addr   = tgt_mem[lk_idx];

  // Resolve side
  assign up_idx = resolve_pc[fetch_pkg::BTB_IDX_W+1:2];
  assign up_tag = resolve_pc[31:fetch_pkg::BTB_IDX_W+2];
  assign up_hit = valid[up_idx] && (tag_mem[up_idx] == up_tag);

  // One saturating step toward the outcome
  function automatic fetch_pkg::ctr_e ctr_step(input fetch_pkg::ctr_e c, input logic taken);
    fetch_pkg::ctr_e n;
    case (c)
      fetch_pkg::STRONG_NT: n = taken ? fetch_pkg::WEAK_NT : fetch_pkg::STRONG_NT;
      fetch_pkg::WEAK_NT:   n = taken ? fetch_pkg::WEAK_T : fetch_pkg::STRONG_NT;
      fetch_pkg::WEAK_T:    n = taken ? fetch_pkg::STRONG_T : fetch_pkg::WEAK_NT;
      default:              n = taken ? fetch_pkg::STRONG_T : fetch_pkg::WEAK_T;
    endcase
    return n;
  endfunction

  // Valid bits, allocation on a taken miss
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid <= '0;
    end else if (update_en && !up_hit && resolve_taken) begin
      valid[up_idx] <= 1'b1;
    end
  end

  // Entry contents
  always_ff @(posedge CLK) begin
    if (update_en) begin
      if (up_hit) begin
        ctr_mem[up_idx] <= ctr_step(ctr_mem[up_idx], resolve_taken);
        // Keep old target on a not-taken resolve
        if (resolve_taken) begin
          tgt_mem[up_idx] <= resolve_target;
        end
      end else if (resolve_taken) begin
        // Fresh entry starts weakly taken
        tag_mem[up_idx] <= up_tag;
        tgt_mem[up_idx] <= resolve_target;
        ctr_mem[up_idx] <= fetch_pkg::WEAK_T;
      end
    end
  end

endmodule

// ==== pc_gen.sv ====
module pc_gen (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              redirect,
  input  fetch_pkg::word_t  redirect_target,
  output logic              req_en,
  output fetch_pkg::word_t  req_addr,
  input  logic              req_done,
  input  logic              resp_valid,
  input  fetch_pkg::word_t  resp_instr,
  output fetch_pkg::word_t  lookup_pc,
  input  logic              predict_taken,
  input  fetch_pkg::word_t  target_addr,
  input  logic              queue_full,
  output logic              push,
  output fetch_pkg::word_t  push_pc,
  output fetch_pkg::word_t  push_pc4,
  output fetch_pkg::word_t  push_instr,
  output logic              push_pred,
  output logic              push_mal
);

  fetch_pkg::fetch_state_e state;
  fetch_pkg::word_t        pc;
  fetch_pkg::word_t        npc;
  // PC and prediction of the access being serviced
  fetch_pkg::word_t        serv_pc;
  logic                    serv_pred;
  logic                    pc_aligned;
  logic                    slot_free;
  logic                    mal_push;

  assign pc_aligned = (pc[1:0] == 2'b00);

  // Room for a packet and no response waiting to be pushed
  assign slot_free = (state == fetch_pkg::FETCH_RUN) && !resp_valid && !queue_full;

  assign req_en   = slot_free && pc_aligned;
  assign mal_push = slot_free && !pc_aligned;
  assign req_addr = pc;

  // BTB is looked up with the current PC
  assign lookup_pc = pc;
  assign npc = predict_taken ? target_addr : pc + 32'd4;

  // PC register and fetch FSM
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc    <= fetch_pkg::RESET_PC;
      state <= fetch_pkg::FETCH_RUN;
    end else if (redirect) begin
      pc    <= redirect_target;
      state <= fetch_pkg::FETCH_RUN;
    end else if (req_done) begin
      pc <= npc;
    end else if (mal_push) begin
      // Hold PC, wait for a redirect
      state <= fetch_pkg::FETCH_HALT;
    end
  end

  // Prediction sampled at completion travels with the packet
  always_ff @(posedge CLK) begin
    if (req_done) begin
      serv_pc   <= pc;
      serv_pred <= predict_taken;
    end
  end

  // Packet build, response and misaligned push never overlap
  assign push       = resp_valid | mal_push;
  assign push_pc    = resp_valid ? serv_pc : pc;
  assign push_pc4   = push_pc + 32'd4;
  assign push_instr = resp_valid ? resp_instr : '0;
  assign push_pred  = resp_valid & serv_pred;
  assign push_mal   = mal_push;

  // Issue rule must keep the FIFO from overflowing
  assert property (@(posedge CLK) disable iff (!nRST)
    push |-> !queue_full);

endmodule

// ==== fetch_out_queue.sv ====
module fetch_out_queue (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              flush,
  input  logic              push,
  input  fetch_pkg::word_t  push_pc,
  input  fetch_pkg::word_t  push_pc4,
  input  fetch_pkg::word_t  push_instr,
  input  logic              push_pred,
  input  logic              push_mal,
  output logic              queue_full,
  input  logic              credit_return,
  output logic              out_valid,
  output fetch_pkg::word_t  out_pc,
  output fetch_pkg::word_t  out_pc4,
  output fetch_pkg::word_t  out_instr,
  output logic              out_pred,
  output logic              out_mal
);

  // Packet storage
  fetch_pkg::word_t pc_mem    [fetch_pkg::QUEUE_DEPTH];
  fetch_pkg::word_t pc4_mem   [fetch_pkg::QUEUE_DEPTH];
  fetch_pkg::word_t instr_mem [fetch_pkg::QUEUE_DEPTH];
  logic             pred_mem  [fetch_pkg::QUEUE_DEPTH];
  logic             mal_mem   [fetch_pkg::QUEUE_DEPTH];

  logic [fetch_pkg::QUEUE_PTR_W-1:0] wr_ptr;
  logic [fetch_pkg::QUEUE_PTR_W-1:0] rd_ptr;
  logic [fetch_pkg::QUEUE_PTR_W:0]   count;
  logic [fetch_pkg::CREDIT_W-1:0]    credits;
  logic                              wr_en;

  assign queue_full = (count == fetch_pkg::QUEUE_DEPTH);
  assign wr_en      = push && !flush;

  // Head goes out when a credit is held
  assign out_valid = (count != '0) && (credits != '0);
  assign out_pc    = pc_mem[rd_ptr];
  assign out_pc4   = pc4_mem[rd_ptr];
  assign out_instr = instr_mem[rd_ptr];
  assign out_pred  = pred_mem[rd_ptr];
  assign out_mal   = mal_mem[rd_ptr];

  // Flush resets pointers and fill level
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (out_valid) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, out_valid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      pc_mem[wr_ptr]    <= push_pc;
      pc4_mem[wr_ptr]   <= push_pc4;
      instr_mem[wr_ptr] <= push_instr;
      pred_mem[wr_ptr]  <= push_pred;
      mal_mem[wr_ptr]   <= push_mal;
    end
  end

  // Credit counter ignores flush
  // Send and return in one cycle cancel out
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      credits <= fetch_pkg::CREDIT_W'(fetch_pkg::EXEC_CREDITS);
    end else begin
      case ({credit_return, out_valid})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // Execute never returns more than it was given
  assert property (@(posedge CLK) disable iff (!nRST)
    credits <= fetch_pkg::EXEC_CREDITS);

  // Writer holds off while the FIFO is full
  assert property (@(posedge CLK) disable iff (!nRST)
    wr_en |-> !queue_full);

endmodule

// ==== fetch_unit.sv ====
module fetch_unit (
  input  logic              CLK,
  input  logic              nRST,
  // Instruction bus
  output fetch_pkg::word_t  imem_addr,
  output logic              imem_ren,
  input  logic              imem_busy,
  input  fetch_pkg::word_t  imem_rdata,
  // Redirect and resolve from execute
  input  logic              redirect,
  input  fetch_pkg::word_t  redirect_target,
  input  fetch_pkg::word_t  resolve_pc,
  input  logic              resolve_taken,
  input  fetch_pkg::word_t  resolve_target,
  // Packet link to execute
  input  logic              credit_return,
  output logic              out_valid,
  output fetch_pkg::word_t  out_pc,
  output fetch_pkg::word_t  out_pc4,
  output fetch_pkg::word_t  out_instr,
  output logic              out_pred,
  output logic              out_mal
);

  // Request and response
  fetch_pkg::word_t req_addr;
  logic             req_en;
  logic             req_done;
  logic             resp_valid;
  fetch_pkg::word_t resp_instr;
  // Predictor
  fetch_pkg::word_t lookup_pc;
  logic             predict_taken;
  fetch_pkg::word_t target_addr;
  // Packet push
  logic             queue_full;
  logic             push;
  fetch_pkg::word_t push_pc;
  fetch_pkg::word_t push_pc4;
  fetch_pkg::word_t push_instr;
  logic             push_pred;
  logic             push_mal;

  fetch_bus_port bus_port_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .req_addr   (req_addr),
    .req_en     (req_en),
    .flush      (redirect),
    .imem_addr  (imem_addr),
    .imem_ren   (imem_ren),
    .imem_busy  (imem_busy),
    .imem_rdata (imem_rdata),
    .req_done   (req_done),
    .resp_valid (resp_valid),
    .resp_instr (resp_instr)
  );

  // Trained by the same pulse that redirects
  branch_predictor predictor_i (
    .CLK            (CLK),
    .nRST           (nRST),
    .lookup_pc      (lookup_pc),
    .predict_taken  (predict_taken),
    .target_addr    (target_addr),
    .update_en      (redirect),
    .resolve_pc     (resolve_pc),
    .resolve_target (resolve_target),
    .resolve_taken  (resolve_taken)
  );

  pc_gen pc_gen_i (
    .CLK             (CLK),
    .nRST            (nRST),
    .redirect        (redirect),
    .redirect_target (redirect_target),
    .req_en          (req_en),
    .req_addr        (req_addr),
    .req_done        (req_done),
    .resp_valid      (resp_valid),
    .resp_instr      (resp_instr),
    .lookup_pc       (lookup_pc),
    .predict_taken   (predict_taken),
    .target_addr     (target_addr),
    .queue_full      (queue_full),
    .push            (push),
    .push_pc         (push_pc),
    .push_pc4        (push_pc4),
    .push_instr      (push_instr),
    .push_pred       (push_pred),
    .push_mal        (push_mal)
  );

  fetch_out_queue out_queue_i (
    .CLK           (CLK),
    .nRST          (nRST),
    .flush         (redirect),
    .push          (push),
    .push_pc       (push_pc),
    .push_pc4      (push_pc4),
    .push_instr    (push_instr),
    .push_pred     (push_pred),
    .push_mal      (push_mal),
    .queue_full    (queue_full),
    .credit_return (credit_return),
    .out_valid     (out_valid),
    .out_pc        (out_pc),
    .out_pc4       (out_pc4),
    .out_instr     (out_instr),
    .out_pred      (out_pred),
    .out_mal       (out_mal)
  );

endmodule

// ==== tb_fetch_model.sv ====
module tb_fetch_model;
  timeunit 1ns;
  timeprecision 1ps;

  // BTB mirror, index from PC bits 5:2, tag from bits 31:6
  logic                            btb_valid  [fetch_pkg::BTB_ENTRIES];
  logic [fetch_pkg::BTB_TAG_W-1:0] btb_tag    [fetch_pkg::BTB_ENTRIES];
  fetch_pkg::word_t                btb_target [fetch_pkg::BTB_ENTRIES];
  fetch_pkg::ctr_e                 btb_ctr    [fetch_pkg::BTB_ENTRIES];

  // Address of the next expected packet
  fetch_pkg::word_t pc;
  // Set once the misaligned packet has gone out
  logic             halted;

  // Word seen by the core: address hash, then byte order fix
  function automatic fetch_pkg::word_t mem_word(input fetch_pkg::word_t a);
    fetch_pkg::word_t raw;
    raw = a ^ {a[18:0], a[31:19]};
    if (fetch_pkg::BUS_LITTLE_ENDIAN) begin
      return {raw[7:0], raw[15:8], raw[23:16], raw[31:24]};
    end
    return raw;
  endfunction

  task automatic clear_btb();
    for (int i = 0; i < fetch_pkg::BTB_ENTRIES; i++) begin
      btb_valid[i] = 1'b0;
      btb_ctr[i]   = fetch_pkg::STRONG_NT;
    end
  endtask

  // New stream after reset or redirect
  task automatic restart(input fetch_pkg::word_t start_pc);
    pc     = start_pc;
    halted = 1'b0;
  endtask

  // Resolve update, applied with the redirect
  task automatic train(input fetch_pkg::word_t rpc, input logic taken,
                       input fetch_pkg::word_t tgt);
    logic [3:0] i;
    logic       hit;
    i   = rpc[5:2];
    hit = btb_valid[i] && (btb_tag[i] == rpc[31:6]);
    if (hit) begin
      if (taken) begin
        btb_target[i] = tgt;
        if (btb_ctr[i] != fetch_pkg::STRONG_T) begin
          btb_ctr[i] = fetch_pkg::ctr_e'(btb_ctr[i] + 2'd1);
        end
      end else if (btb_ctr[i] != fetch_pkg::STRONG_NT) begin
        btb_ctr[i] = fetch_pkg::ctr_e'(btb_ctr[i] - 2'd1);
      end
    end else if (taken) begin
      // Taken miss allocates weakly taken
      btb_valid[i]  = 1'b1;
      btb_tag[i]    = rpc[31:6];
      btb_target[i] = tgt;
      btb_ctr[i]    = fetch_pkg::WEAK_T;
    end
  endtask

  // Next packet of the stream, advances the model PC
  task automatic expect_packet(output fetch_pkg::word_t e_pc, output fetch_pkg::word_t e_pc4,
                               output fetch_pkg::word_t e_instr, output logic e_pred,
                               output logic e_mal);
    logic [3:0] i;
    i     = pc[5:2];
    e_pc  = pc;
    e_pc4 = pc + 32'd4;
    if (pc[1:0] != 2'b00) begin
      // No bus read, empty packet, then halt
      e_instr = '0;
      e_pred  = 1'b0;
      e_mal   = 1'b1;
      halted  = 1'b1;
    end else begin
      e_instr = mem_word(pc);
      e_pred  = btb_valid[i] && (btb_tag[i] == pc[31:6]) &&
                (btb_ctr[i] == fetch_pkg::WEAK_T || btb_ctr[i] == fetch_pkg::STRONG_T);
      e_mal   = 1'b0;
      pc      = e_pred ? btb_target[i] : pc + 32'd4;
    end
  endtask

endmodule

// ==== tb_fetch_unit.sv ====
module tb_fetch_unit;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_PACKETS    = 400;
  // Per-packet budget covers busy, credit and halt waits
  localparam int TIMEOUT_CYCLES = NUM_PACKETS * 40;
  // Longest quiet gap while fetch should be running
  localparam int STALL_LIMIT    = 40;

  logic             CLK;
  logic             nRST;
  fetch_pkg::word_t imem_addr;
  logic             imem_ren;
  logic             imem_busy;
  fetch_pkg::word_t imem_rdata;
  logic             redirect;
  fetch_pkg::word_t redirect_target;
  fetch_pkg::word_t resolve_pc;
  logic             resolve_taken;
  fetch_pkg::word_t resolve_target;
  logic             credit_return;
  logic             out_valid;
  fetch_pkg::word_t out_pc;
  fetch_pkg::word_t out_pc4;
  fetch_pkg::word_t out_instr;
  logic             out_pred;
  logic             out_mal;

  int    seed;
  int    cycle_count = 0;
  string test_name;

  fetch_unit dut_i (
    .CLK             (CLK),
    .nRST            (nRST),
    .imem_addr       (imem_addr),
    .imem_ren        (imem_ren),
    .imem_busy       (imem_busy),
    .imem_rdata      (imem_rdata),
    .redirect        (redirect),
    .redirect_target (redirect_target),
    .resolve_pc      (resolve_pc),
    .resolve_taken   (resolve_taken),
    .resolve_target  (resolve_target),
    .credit_return   (credit_return),
    .out_valid       (out_valid),
    .out_pc          (out_pc),
    .out_pc4         (out_pc4),
    .out_instr       (out_instr),
    .out_pred        (out_pred),
    .out_mal         (out_mal)
  );

  tb_fetch_model model_i ();

  // Memory answers every address with a hash of it
  assign imem_rdata = imem_addr ^ {imem_addr[18:0], imem_addr[31:19]};

  initial CLK = 1'b0;
  always #50 CLK = ~CLK;

  task automatic fail_and_stop(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_word(input string field, input fetch_pkg::word_t exp,
                            input fetch_pkg::word_t act);
    if (act !== exp) begin
      fail_and_stop($sformatf("ERR %s %s: expected %h actual %h", test_name, field, exp, act));
    end
  endtask

  task automatic check_bit(input string field, input logic exp, input logic act);
    if (act !== exp) begin
      fail_and_stop($sformatf("ERR %s %s: expected %b actual %b", test_name, field, exp, act));
    end
  endtask

  task automatic roll(input int unsigned range, output int unsigned value);
    logic [31:0] r;
    r     = $random(seed);
    value = r % range;
  endtask

  // Run limit
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_and_stop($sformatf("Timeout: %0d packets not received within %0d cycles",
                              NUM_PACKETS, TIMEOUT_CYCLES));
    end
  end

  initial begin
    fetch_pkg::word_t e_pc;
    fetch_pkg::word_t e_pc4;
    fetch_pkg::word_t e_instr;
    fetch_pkg::word_t last_pc;
    logic             e_pred;
    logic             e_mal;
    int unsigned      r;
    int               outstanding;
    int               pkt_count;
    int               since_redirect;
    int               redirect_gap;
    int               stall_cycles;
    int               halt_cycles;
    int               halt_wait;

    seed            = 32'h7b49f4e8;
    nRST            = 1'b0;
    imem_busy       = 1'b0;
    redirect        = 1'b0;
    redirect_target = '0;
    resolve_pc      = '0;
    resolve_taken   = 1'b0;
    resolve_target  = '0;
    credit_return   = 1'b0;
    test_name       = "reset_fetch";
    outstanding     = 0;
    pkt_count       = 0;
    since_redirect  = 0;
    stall_cycles    = 0;
    halt_cycles     = 0;
    halt_wait       = 0;
    last_pc         = fetch_pkg::RESET_PC;
    model_i.clear_btb();
    model_i.restart(fetch_pkg::RESET_PC);
    roll(13, r);
    redirect_gap = 8 + int'(r);

    repeat (2) begin
      @(negedge CLK);
      // Bus stays idle while reset is held
      check_bit("imem_ren", 1'b0, imem_ren);
    end
    nRST = 1'b1;

    while (pkt_count < NUM_PACKETS) begin
      @(negedge CLK);

      // Bus reads are word aligned
      if (imem_ren && imem_addr[1:0] != 2'b00) begin
        fail_and_stop("a bus read was issued at a misaligned address");
      end
      // No bus reads once the misaligned packet is out
      if (model_i.halted) begin
        check_bit("imem_ren", 1'b0, imem_ren);
      end

      // Sample the packet of this cycle first
      if (out_valid) begin
        if (outstanding >= fetch_pkg::EXEC_CREDITS) begin
          fail_and_stop("out_valid arrived while the execute stage had no free credit");
        end
        if (model_i.halted) begin
          fail_and_stop("a packet arrived while fetch should be halted on a misaligned PC");
        end
        model_i.expect_packet(e_pc, e_pc4, e_instr, e_pred, e_mal);
        check_word("pc", e_pc, out_pc);
        check_word("pc4", e_pc4, out_pc4);
        check_word("instr", e_instr, out_instr);
        check_bit("pred", e_pred, out_pred);
        check_bit("mal", e_mal, out_mal);
        outstanding++;
        pkt_count++;
        since_redirect++;
        last_pc      = out_pc;
        stall_cycles = 0;
        if (e_mal) begin
          // Watch a few quiet cycles before the next redirect
          halt_cycles = 0;
          roll(8, r);
          halt_wait = 4 + int'(r);
        end else begin
          test_name = "predicted_stream";
        end
      end else if (model_i.halted) begin
        halt_cycles++;
      end else begin
        stall_cycles++;
        if (stall_cycles > STALL_LIMIT) begin
          fail_and_stop("packets stopped although credits and memory allowed progress");
        end
      end

      // Redirect is a single-cycle pulse
      if (redirect) begin
        redirect = 1'b0;
      end else if ((model_i.halted && halt_cycles >= halt_wait) ||
                   (!model_i.halted && since_redirect >= redirect_gap)) begin
        // Small window so BTB entries get hit again
        roll(64, r);
        redirect_target = 32'h200 + (r << 2);
        roll(8, r);
        if (r == 0) begin
          roll(3, r);
          redirect_target = redirect_target + 32'd1 + r;
          test_name = "misaligned_halt";
        end else begin
          test_name = "redirect_stream";
        end
        resolve_pc = last_pc;
        roll(2, r);
        resolve_taken = r[0];
        roll(64, r);
        resolve_target = 32'h200 + (r << 2);
        redirect = 1'b1;
        model_i.train(resolve_pc, resolve_taken, resolve_target);
        model_i.restart(redirect_target);
        since_redirect = 0;
        stall_cycles   = 0;
        halt_cycles    = 0;
        roll(13, r);
        redirect_gap = 8 + int'(r);
      end

      // Busy about 30 percent of cycles
      roll(10, r);
      imem_busy = (r < 3);

      // Only credits already spent go back
      credit_return = 1'b0;
      if (outstanding > 0) begin
        roll(2, r);
        credit_return = r[0];
        if (credit_return) begin
          outstanding--;
        end
      end
    end

    $display("TEST OK");
    $finish;
  end

endmodule

// ==== fetch_unit.f ====
fetch_pkg.sv
fetch_bus_port.sv
branch_predictor.sv
pc_gen.sv
fetch_out_queue.sv
fetch_unit.sv
tb_fetch_model.sv
tb_fetch_unit.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

# Warnings stay visible but do not stop the build
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fetch_unit -f fetch_unit.f -o sim_fetch_unit
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_fetch_unit 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

# Pass only when the testbench reported success
if echo "$sim_out" | grep -q "^TEST OK$"; then
  exit 0
fi
exit 1
